/* filelist.f */
+incdir+tests
hw/axi_pkg.sv
hw/sys_map_pkg.sv
hw/sys_axi_decode.sv
hw/sys_ctrl_regs.sv
hw/sys_timer.sv
hw/sys_intc.sv
hw/sys_axi_response.sv
hw/sys_periph_top.sv
tests/tb_sys_periph.sv

/* hw/axi_pkg.sv */
//####################################################################
// AXI bus types shared by the system-register slave
//####################################################################
package axi_pkg;

	localparam int AXI_ADDR_WIDTH = 32;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_RESP_WIDTH = 2;

	// byte address as seen on AW and AR
	typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;

	// one data beat on W and R
	typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

	// B and R response code
	typedef logic [AXI_RESP_WIDTH-1:0] axi_resp_t;

	// only these two are ever returned
	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

/* hw/sys_axi_decode.sv */
//####################################################################
// AXI front end, takes AW/W/AR handshakes and issues register strobes
//####################################################################
`timescale 1ns/100ps

module sys_axi_decode
	import axi_pkg::*;
	import sys_map_pkg::*;
#(
	parameter int ID_WIDTH = 5
) (
	input  logic                core_clk,
	input  logic                rst_n,
	input  logic                i_awvalid,
	input  axi_addr_t           i_awaddr,
	input  logic [ID_WIDTH-1:0] i_awid,
	input  logic                i_wvalid,
	input  axi_data_t           i_wdata,
	input  logic                i_arvalid,
	input  axi_addr_t           i_araddr,
	input  logic [ID_WIDTH-1:0] i_arid,
	input  logic                i_rd_busy,
	input  logic                i_wr_busy,
	output logic                o_awready,
	output logic                o_wready,
	output logic                o_arready,
	output logic                o_wr_stb,
	output sys_region_e         o_wr_region,
	output reg_off_t            o_wr_off,
	output axi_data_t           o_wr_data,
	output logic [ID_WIDTH-1:0] o_wr_id,
	output logic                o_rd_stb,
	output sys_region_e         o_rd_region,
	output reg_off_t            o_rd_off,
	output logic [ID_WIDTH-1:0] o_rd_id
);

	typedef enum logic {WR_IDLE, WR_WAIT_DATA} wr_state_e;
	typedef enum logic {RD_IDLE, RD_ISSUE} rd_state_e;

	wr_state_e wr_state;
	rd_state_e rd_state;
	axi_addr_t wr_addr_q;
	axi_addr_t rd_addr_q;
	logic      wr_stb_q;

	function automatic sys_region_e addr_region(input axi_addr_t addr);
		case (addr[REGION_MSB:REGION_LSB])
			4'd0:    return REGION_CTRL;
			4'd1:    return REGION_TIMER;
			4'd2:    return REGION_INTC;
			default: return REGION_NONE;
		endcase
	endfunction

	// no new address while a response is still owed
	assign o_awready = (wr_state == WR_IDLE) && !i_wr_busy;
	assign o_wready  = (wr_state == WR_WAIT_DATA);
	assign o_arready = (rd_state == RD_IDLE) && !i_rd_busy;

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
			wr_stb_q <= 1'b0;
		end else begin
			wr_stb_q <= 1'b0;
			case (wr_state)
				WR_IDLE: begin
					if (i_awvalid && o_awready)
						wr_state <= WR_WAIT_DATA;
				end
				WR_WAIT_DATA: begin
					if (i_wvalid) begin
						wr_state <= WR_IDLE;
						wr_stb_q <= 1'b1;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// issue lasts exactly one cycle
	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (i_arvalid && o_arready)
						rd_state <= RD_ISSUE;
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// address, id and data capture
	always_ff @(posedge core_clk) begin
		if (i_awvalid && o_awready) begin
			wr_addr_q <= i_awaddr;
			o_wr_id   <= i_awid;
		end
		if (i_wvalid && o_wready)
			o_wr_data <= i_wdata;
		if (i_arvalid && o_arready) begin
			rd_addr_q <= i_araddr;
			o_rd_id   <= i_arid;
		end
	end

	assign o_wr_stb    = wr_stb_q;
	assign o_wr_region = addr_region(wr_addr_q);
	assign o_wr_off    = wr_addr_q[OFF_MSB:OFF_LSB];

	assign o_rd_stb    = (rd_state == RD_ISSUE);
	assign o_rd_region = addr_region(rd_addr_q);
	assign o_rd_off    = rd_addr_q[OFF_MSB:OFF_LSB];

endmodule

/* hw/sys_axi_response.sv */
//####################################################################
// R and B channel registers, held until the master takes them
//####################################################################
`timescale 1ns/100ps

module sys_axi_response
	import axi_pkg::*;
	import sys_map_pkg::*;
#(
	parameter int ID_WIDTH = 5
) (
	input  logic                core_clk,
	input  logic                rst_n,
	input  logic                i_wr_stb,
	input  sys_region_e         i_wr_region,
	input  logic [ID_WIDTH-1:0] i_wr_id,
	input  logic                i_rd_stb,
	input  sys_region_e         i_rd_region,
	input  logic [ID_WIDTH-1:0] i_rd_id,
	input  axi_data_t           i_ctrl_data,
	input  axi_data_t           i_timer_data,
	input  axi_data_t           i_intc_data,
	input  logic                i_bready,
	input  logic                i_rready,
	output logic                o_bvalid,
	output logic [ID_WIDTH-1:0] o_bid,
	output axi_resp_t           o_bresp,
	output logic                o_rvalid,
	output axi_data_t           o_rdata,
	output logic [ID_WIDTH-1:0] o_rid,
	output axi_resp_t           o_rresp,
	output logic                o_rlast,
	output logic                o_rd_busy,
	output logic                o_wr_busy
);

	axi_data_t rd_word;
	axi_resp_t rd_resp;

	always_comb begin
		rd_resp = RESP_OKAY;
		case (i_rd_region)
			REGION_CTRL:  rd_word = i_ctrl_data;
			REGION_TIMER: rd_word = i_timer_data;
			REGION_INTC:  rd_word = i_intc_data;
			default: begin
				rd_word = '0;
				rd_resp = RESP_SLVERR;
			end
		endcase
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			o_rvalid <= 1'b0;
			o_rdata  <= '0;
			o_rid    <= '0;
			o_rresp  <= RESP_OKAY;
		end else if (i_rd_stb) begin
			o_rvalid <= 1'b1;
			o_rdata  <= rd_word;
			o_rid    <= i_rd_id;
			o_rresp  <= rd_resp;
		end else if (i_rready) begin
			o_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			o_bvalid <= 1'b0;
			o_bid    <= '0;
			o_bresp  <= RESP_OKAY;
		end else if (i_wr_stb) begin
			o_bvalid <= 1'b1;
			o_bid    <= i_wr_id;
			o_bresp  <= (i_wr_region == REGION_NONE) ? RESP_SLVERR : RESP_OKAY;
		end else if (i_bready) begin
			o_bvalid <= 1'b0;
		end
	end

	// single beat reads only
	assign o_rlast   = o_rvalid;
	assign o_rd_busy = o_rvalid;
	// strobe cycle counts as busy so AW stays closed until B is up
	assign o_wr_busy = o_bvalid || i_wr_stb;

endmodule

/* hw/sys_ctrl_regs.sv */
//####################################################################
// control block with LED, scratch and core identity registers
//####################################################################
`timescale 1ns/100ps

module sys_ctrl_regs
	import axi_pkg::*;
	import sys_map_pkg::*;
#(
	parameter int CORE_ID   = 0,
	parameter int LED_WIDTH = 4
) (
	input  logic                 core_clk,
	input  logic                 rst_n,
	input  logic                 i_wr_stb,
	input  sys_region_e          i_wr_region,
	input  reg_off_t             i_wr_off,
	input  axi_data_t            i_wr_data,
	input  reg_off_t             i_rd_off,
	output axi_data_t            o_rd_data,
	output logic [LED_WIDTH-1:0] o_led
);

	logic [LED_WIDTH-1:0] led_q;
	axi_data_t            scratch_q;
	logic                 wr_hit;

	assign wr_hit = i_wr_stb && (i_wr_region == REGION_CTRL);

	always_ff @(posedge core_clk) begin
		if (!rst_n)
			led_q <= '0;
		else if (wr_hit && i_wr_off == CTRL_LED_OFF)
			led_q <= i_wr_data[LED_WIDTH-1:0];
	end

	always_ff @(posedge core_clk) begin
		if (wr_hit && i_wr_off == CTRL_SCRATCH_OFF)
			scratch_q <= i_wr_data;
	end

	// coreid is a constant, writes fall through
	always_comb begin
		case (i_rd_off)
			CTRL_LED_OFF:     o_rd_data = axi_data_t'(led_q);
			CTRL_SCRATCH_OFF: o_rd_data = scratch_q;
			CTRL_COREID_OFF:  o_rd_data = axi_data_t'(CORE_ID);
			default:          o_rd_data = '0;
		endcase
	end

	assign o_led = led_q;

endmodule

/* hw/sys_intc.sv */
//####################################################################
// interrupt controller, routes enabled sources to irq or firq
//####################################################################
`timescale 1ns/100ps

module sys_intc
	import axi_pkg::*;
	import sys_map_pkg::*;
(
	input  logic        core_clk,
	input  logic        rst_n,
	input  logic        i_wr_stb,
	input  sys_region_e i_wr_region,
	input  reg_off_t    i_wr_off,
	input  axi_data_t   i_wr_data,
	input  reg_off_t    i_rd_off,
	input  logic        i_timer_irq,
	input  logic [3:0]  i_ext_irq,
	output axi_data_t   o_rd_data,
	output logic        o_irq,
	output logic        o_firq
);

	irq_vec_t src;
	irq_vec_t enable_q;
	irq_vec_t firq_sel_q;
	irq_vec_t active;
	logic     wr_hit;

	// bits 3:1 are reserved
	assign src = {i_ext_irq, 3'b000, i_timer_irq};

	assign wr_hit = i_wr_stb && (i_wr_region == REGION_INTC);

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			enable_q   <= '0;
			firq_sel_q <= '0;
		end else if (wr_hit) begin
			if (i_wr_off == INTC_ENABLE_OFF)
				enable_q <= i_wr_data[7:0];
			if (i_wr_off == INTC_FIRQ_SEL_OFF)
				firq_sel_q <= i_wr_data[7:0];
		end
	end

	assign active = src & enable_q;
	assign o_firq = |(active & firq_sel_q);
	assign o_irq  = |(active & ~firq_sel_q);

	// status shows raw levels, not masked
	always_comb begin
		case (i_rd_off)
			INTC_STATUS_OFF:   o_rd_data = axi_data_t'(src);
			INTC_ENABLE_OFF:   o_rd_data = axi_data_t'(enable_q);
			INTC_FIRQ_SEL_OFF: o_rd_data = axi_data_t'(firq_sel_q);
			default:           o_rd_data = '0;
		endcase
	end

endmodule

/* hw/sys_map_pkg.sv */
//####################################################################
// address map, register offsets and interrupt vector of the slave
//####################################################################
package sys_map_pkg;

	// region select and word offset positions in the address
	localparam int REGION_MSB = 15;
	localparam int REGION_LSB = 12;
	localparam int OFF_MSB    = 9;
	localparam int OFF_LSB    = 2;

	typedef logic [OFF_MSB-OFF_LSB:0] reg_off_t;

	typedef enum logic [1:0] {
		REGION_CTRL  = 2'd0,
		REGION_TIMER = 2'd1,
		REGION_INTC  = 2'd2,
		REGION_NONE  = 2'd3
	} sys_region_e;

	// control block
	localparam reg_off_t CTRL_LED_OFF      = 8'h00;
	localparam reg_off_t CTRL_SCRATCH_OFF  = 8'h01;
	localparam reg_off_t CTRL_COREID_OFF   = 8'h02;

	// timer, ctrl bit0 enable and bit1 periodic
	localparam reg_off_t TIMER_LOAD_OFF    = 8'h00;
	localparam reg_off_t TIMER_CTRL_OFF    = 8'h01;
	localparam reg_off_t TIMER_VALUE_OFF   = 8'h02;
	localparam reg_off_t TIMER_CLEAR_OFF   = 8'h03;

	// interrupt controller
	localparam reg_off_t INTC_STATUS_OFF   = 8'h00;
	localparam reg_off_t INTC_ENABLE_OFF   = 8'h01;
	localparam reg_off_t INTC_FIRQ_SEL_OFF = 8'h02;

	// bit 0 timer, bits 7:4 external lines
	typedef logic [7:0] irq_vec_t;

endpackage

/* hw/sys_periph_top.sv */
//####################################################################
// system register slave top, decode, execute blocks and response
//####################################################################
`timescale 1ns/100ps

module sys_periph_top
	import axi_pkg::*;
	import sys_map_pkg::*;
#(
	parameter int ID_WIDTH  = 5,
	parameter int CORE_ID   = 0,
	parameter int LED_WIDTH = 4
) (
	input  logic                 core_clk,
	input  logic                 rst_n,
	input  logic                 i_awvalid,
	output logic                 o_awready,
	input  axi_addr_t            i_awaddr,
	input  logic [ID_WIDTH-1:0]  i_awid,
	input  logic                 i_wvalid,
	output logic                 o_wready,
	input  axi_data_t            i_wdata,
	output logic                 o_bvalid,
	input  logic                 i_bready,
	output logic [ID_WIDTH-1:0]  o_bid,
	output axi_resp_t            o_bresp,
	input  logic                 i_arvalid,
	output logic                 o_arready,
	input  axi_addr_t            i_araddr,
	input  logic [ID_WIDTH-1:0]  i_arid,
	output logic                 o_rvalid,
	input  logic                 i_rready,
	output axi_data_t            o_rdata,
	output logic [ID_WIDTH-1:0]  o_rid,
	output axi_resp_t            o_rresp,
	output logic                 o_rlast,
	output logic [LED_WIDTH-1:0] o_led,
	output logic                 o_irq,
	output logic                 o_firq,
	input  logic [3:0]           i_ext_irq
);

	logic                wr_stb;
	sys_region_e         wr_region;
	reg_off_t            wr_off;
	axi_data_t           wr_data;
	logic [ID_WIDTH-1:0] wr_id;
	logic                rd_stb;
	sys_region_e         rd_region;
	reg_off_t            rd_off;
	logic [ID_WIDTH-1:0] rd_id;
	logic                rd_busy;
	logic                wr_busy;
	axi_data_t           ctrl_rd_data;
	axi_data_t           timer_rd_data;
	axi_data_t           intc_rd_data;
	logic                timer_expired;

	sys_axi_decode #(
		.ID_WIDTH    (ID_WIDTH)
	) sys_axi_decode_i (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_awvalid   (i_awvalid),
		.i_awaddr    (i_awaddr),
		.i_awid      (i_awid),
		.i_wvalid    (i_wvalid),
		.i_wdata     (i_wdata),
		.i_arvalid   (i_arvalid),
		.i_araddr    (i_araddr),
		.i_arid      (i_arid),
		.i_rd_busy   (rd_busy),
		.i_wr_busy   (wr_busy),
		.o_awready   (o_awready),
		.o_wready    (o_wready),
		.o_arready   (o_arready),
		.o_wr_stb    (wr_stb),
		.o_wr_region (wr_region),
		.o_wr_off    (wr_off),
		.o_wr_data   (wr_data),
		.o_wr_id     (wr_id),
		.o_rd_stb    (rd_stb),
		.o_rd_region (rd_region),
		.o_rd_off    (rd_off),
		.o_rd_id     (rd_id)
	);

	sys_ctrl_regs #(
		.CORE_ID     (CORE_ID),
		.LED_WIDTH   (LED_WIDTH)
	) sys_ctrl_regs_i (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_wr_stb    (wr_stb),
		.i_wr_region (wr_region),
		.i_wr_off    (wr_off),
		.i_wr_data   (wr_data),
		.i_rd_off    (rd_off),
		.o_rd_data   (ctrl_rd_data),
		.o_led       (o_led)
	);

	sys_timer sys_timer_i (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_wr_stb    (wr_stb),
		.i_wr_region (wr_region),
		.i_wr_off    (wr_off),
		.i_wr_data   (wr_data),
		.i_rd_off    (rd_off),
		.o_rd_data   (timer_rd_data),
		.o_expired   (timer_expired)
	);

	sys_intc sys_intc_i (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_wr_stb    (wr_stb),
		.i_wr_region (wr_region),
		.i_wr_off    (wr_off),
		.i_wr_data   (wr_data),
		.i_rd_off    (rd_off),
		.i_timer_irq (timer_expired),
		.i_ext_irq   (i_ext_irq),
		.o_rd_data   (intc_rd_data),
		.o_irq       (o_irq),
		.o_firq      (o_firq)
	);

	sys_axi_response #(
		.ID_WIDTH     (ID_WIDTH)
	) sys_axi_response_i (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.i_wr_stb     (wr_stb),
		.i_wr_region  (wr_region),
		.i_wr_id      (wr_id),
		.i_rd_stb     (rd_stb),
		.i_rd_region  (rd_region),
		.i_rd_id      (rd_id),
		.i_ctrl_data  (ctrl_rd_data),
		.i_timer_data (timer_rd_data),
		.i_intc_data  (intc_rd_data),
		.i_bready     (i_bready),
		.i_rready     (i_rready),
		.o_bvalid     (o_bvalid),
		.o_bid        (o_bid),
		.o_bresp      (o_bresp),
		.o_rvalid     (o_rvalid),
		.o_rdata      (o_rdata),
		.o_rid        (o_rid),
		.o_rresp      (o_rresp),
		.o_rlast      (o_rlast),
		.o_rd_busy    (rd_busy),
		.o_wr_busy    (wr_busy)
	);

endmodule

/* hw/sys_timer.sv */
//####################################################################
// down counting timer, one-shot or periodic, sticky expiry flag
//####################################################################
`timescale 1ns/100ps

module sys_timer
	import axi_pkg::*;
	import sys_map_pkg::*;
(
	input  logic        core_clk,
	input  logic        rst_n,
	input  logic        i_wr_stb,
	input  sys_region_e i_wr_region,
	input  reg_off_t    i_wr_off,
	input  axi_data_t   i_wr_data,
	input  reg_off_t    i_rd_off,
	output axi_data_t   o_rd_data,
	output logic        o_expired
);

	axi_data_t load_q;
	axi_data_t count_q;
	logic      enable_q;
	logic      periodic_q;
	logic      expired_q;
	logic      wr_hit;
	logic      tick_zero;

	assign wr_hit = i_wr_stb && (i_wr_region == REGION_TIMER);

	// the step from 1 to 0
	assign tick_zero = enable_q && (count_q == axi_data_t'(1));

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			load_q     <= '0;
			count_q    <= '0;
			enable_q   <= 1'b0;
			periodic_q <= 1'b0;
		end else if (wr_hit && i_wr_off == TIMER_LOAD_OFF) begin
			load_q  <= i_wr_data;
			count_q <= i_wr_data;
		end else if (wr_hit && i_wr_off == TIMER_CTRL_OFF) begin
			enable_q   <= i_wr_data[0];
			periodic_q <= i_wr_data[1];
		end else if (tick_zero) begin
			if (periodic_q) begin
				count_q <= load_q;
			end else begin
				count_q  <= '0;
				enable_q <= 1'b0;
			end
		end else if (enable_q && count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	// a new expiry wins over a clear in the same cycle
	always_ff @(posedge core_clk) begin
		if (!rst_n)
			expired_q <= 1'b0;
		else if (tick_zero)
			expired_q <= 1'b1;
		else if (wr_hit && i_wr_off == TIMER_CLEAR_OFF)
			expired_q <= 1'b0;
	end

	always_comb begin
		case (i_rd_off)
			TIMER_LOAD_OFF:  o_rd_data = load_q;
			TIMER_CTRL_OFF:  o_rd_data = {30'd0, periodic_q, enable_q};
			TIMER_VALUE_OFF: o_rd_data = count_q;
			default:         o_rd_data = '0;
		endcase
	end

	assign o_expired = expired_q;

endmodule

/* tests/tb_sys_periph_tasks.svh */
//####################################################################
// LFSR random source and the AXI master tasks for the slave testbench
//####################################################################
`ifndef TB_SYS_PERIPH_TASKS_SVH
`define TB_SYS_PERIPH_TASKS_SVH

// fibonacci form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v      = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

// back-pressure of 0 to 7 cycles
task automatic stall_cycles();
	int n;
	n = int'(rand_bits(3));
	repeat (n) @(posedge core_clk);
endtask

task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp);
	logic [31:0]         rnd;
	logic [ID_WIDTH-1:0] id;
	rnd = rand_bits(ID_WIDTH);
	id  = rnd[ID_WIDTH-1:0];
	@(posedge core_clk);
	i_awvalid <= 1'b1;
	i_awaddr  <= addr;
	i_awid    <= id;
	do @(posedge core_clk); while (!o_awready);
	i_awvalid <= 1'b0;
	i_wvalid  <= 1'b1;
	i_wdata   <= data;
	do @(posedge core_clk); while (!o_wready);
	i_wvalid  <= 1'b0;
	do @(posedge core_clk); while (!o_bvalid);
	stall_cycles();
	i_bready <= 1'b1;
	@(posedge core_clk);
	i_bready <= 1'b0;
	check_value("o_bid", 32'(o_bid), 32'(id));
	check_value("o_bresp", 32'(o_bresp), 32'(exp_resp));
endtask

task automatic axi_read(input logic [31:0] addr, input logic [1:0] exp_resp,
		output logic [31:0] data);
	logic [31:0]         rnd;
	logic [ID_WIDTH-1:0] id;
	rnd = rand_bits(ID_WIDTH);
	id  = rnd[ID_WIDTH-1:0];
	@(posedge core_clk);
	i_arvalid <= 1'b1;
	i_araddr  <= addr;
	i_arid    <= id;
	do @(posedge core_clk); while (!o_arready);
	i_arvalid <= 1'b0;
	do @(posedge core_clk); while (!o_rvalid);
	stall_cycles();
	i_rready <= 1'b1;
	@(posedge core_clk);
	i_rready <= 1'b0;
	data = o_rdata;
	check_value("o_rid", 32'(o_rid), 32'(id));
	check_value("o_rresp", 32'(o_rresp), 32'(exp_resp));
endtask

`endif

/* tests/tb_sys_periph.sv */
//####################################################################
// testbench for the system register slave, AXI master and checks
//####################################################################
`timescale 1ns/100ps

module tb_sys_periph;

	localparam int ID_WIDTH  = 5;
	localparam int CORE_ID   = 3;
	localparam int LED_WIDTH = 4;

	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	// bits 15:12 pick the region, 9:2 the register
	localparam logic [31:0] LED_ADDR     = 32'h8000_0000;
	localparam logic [31:0] SCRATCH_ADDR = 32'h8000_0004;
	localparam logic [31:0] COREID_ADDR  = 32'h8000_0008;
	localparam logic [31:0] TLOAD_ADDR   = 32'h8000_1000;
	localparam logic [31:0] TCTRL_ADDR   = 32'h8000_1004;
	localparam logic [31:0] TVALUE_ADDR  = 32'h8000_1008;
	localparam logic [31:0] TCLEAR_ADDR  = 32'h8000_100c;
	localparam logic [31:0] STATUS_ADDR  = 32'h8000_2000;
	localparam logic [31:0] ENABLE_ADDR  = 32'h8000_2004;
	localparam logic [31:0] FSEL_ADDR    = 32'h8000_2008;
	localparam logic [31:0] BAD_ADDR_A   = 32'h8000_3000;
	localparam logic [31:0] BAD_ADDR_B   = 32'h8000_f008;

	localparam int LOAD_ONESHOT   = 25;
	localparam int LOAD_MASKED    = 10;
	localparam int N_TRANS        = 31;
	localparam int TIMEOUT_CYCLES = 40 * N_TRANS + 4 * LOAD_ONESHOT;

	logic                 core_clk;
	logic                 rst_n;
	logic                 i_awvalid;
	logic [31:0]          i_awaddr;
	logic [ID_WIDTH-1:0]  i_awid;
	logic                 i_wvalid;
	logic [31:0]          i_wdata;
	logic                 i_bready;
	logic                 i_arvalid;
	logic [31:0]          i_araddr;
	logic [ID_WIDTH-1:0]  i_arid;
	logic                 i_rready;
	logic [3:0]           i_ext_irq;
	logic                 o_awready;
	logic                 o_wready;
	logic                 o_bvalid;
	logic [ID_WIDTH-1:0]  o_bid;
	logic [1:0]           o_bresp;
	logic                 o_arready;
	logic                 o_rvalid;
	logic [31:0]          o_rdata;
	logic [ID_WIDTH-1:0]  o_rid;
	logic [1:0]           o_rresp;
	logic                 o_rlast;
	logic [LED_WIDTH-1:0] o_led;
	logic                 o_irq;
	logic                 o_firq;

	logic [31:0] lfsr_q;
	logic [31:0] rnd;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic [3:0]  ext;
	logic [7:0]  en;
	logic [7:0]  sel;
	logic        exp_irq;
	logic        exp_firq;
	int          waited;
	int          assert_errs = 0;
	int          value_errs  = 0;
	int          cycle_cnt   = 0;

	sys_periph_top #(
		.ID_WIDTH  (ID_WIDTH),
		.CORE_ID   (CORE_ID),
		.LED_WIDTH (LED_WIDTH)
	) sys_periph_top_i (
		.core_clk  (core_clk),
		.rst_n     (rst_n),
		.i_awvalid (i_awvalid),
		.o_awready (o_awready),
		.i_awaddr  (i_awaddr),
		.i_awid    (i_awid),
		.i_wvalid  (i_wvalid),
		.o_wready  (o_wready),
		.i_wdata   (i_wdata),
		.o_bvalid  (o_bvalid),
		.i_bready  (i_bready),
		.o_bid     (o_bid),
		.o_bresp   (o_bresp),
		.i_arvalid (i_arvalid),
		.o_arready (o_arready),
		.i_araddr  (i_araddr),
		.i_arid    (i_arid),
		.o_rvalid  (o_rvalid),
		.i_rready  (i_rready),
		.o_rdata   (o_rdata),
		.o_rid     (o_rid),
		.o_rresp   (o_rresp),
		.o_rlast   (o_rlast),
		.o_led     (o_led),
		.o_irq     (o_irq),
		.o_firq    (o_firq),
		.i_ext_irq (i_ext_irq)
	);

	initial core_clk = 1'b0;
	always #20 core_clk = ~core_clk;

	function automatic void check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else begin
			value_errs++;
			$display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endfunction

	function automatic void assert_failed(input string what);
		assert_errs++;
		$display("assertion failed at %0t: %s", $time, what);
	endfunction

	function automatic void print_counts();
		$display("errors: assertions %0d, values %0d", assert_errs, value_errs);
	endfunction

	`include "tb_sys_periph_tasks.svh"

	reset_state: assert property (@(posedge core_clk) $rose(rst_n) |->
		(o_awready && o_arready && !o_wready && !o_bvalid && !o_rvalid &&
		!o_irq && !o_firq && o_led == '0))
	else assert_failed("outputs are not in their reset state after reset");

	b_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp))
	else assert_failed("write response changed before i_bready");

	r_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_rvalid && !i_rready |=>
		o_rvalid && $stable(o_rdata) && $stable(o_rid) && $stable(o_rresp))
	else assert_failed("read data changed before i_rready");

	// W handshake to o_bvalid in exactly one cycle
	b_latency: assert property (@(posedge core_clk) disable iff (!rst_n)
		$past(o_wready && i_wvalid, 2) |-> o_bvalid && !$past(o_bvalid))
	else assert_failed("o_bvalid did not rise one cycle after the W handshake");

	r_latency: assert property (@(posedge core_clk) disable iff (!rst_n)
		$past(o_arready && i_arvalid, 2) |-> o_rvalid && !$past(o_rvalid))
	else assert_failed("o_rvalid did not rise one cycle after the AR handshake");

	ar_return: assert property (@(posedge core_clk) disable iff (!rst_n)
		$past(o_rvalid && i_rready) |-> o_arready)
	else assert_failed("o_arready did not return after the R handshake");

	ready_low: assert property (@(posedge core_clk) disable iff (!rst_n)
		!(o_rvalid && o_arready) && !(o_bvalid && o_awready))
	else assert_failed("address ready was high while a response was pending");

	rlast_track: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_rlast == o_rvalid)
	else assert_failed("o_rlast does not follow o_rvalid");

	always @(posedge core_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_counts();
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		rst_n     = 1'b0;
		i_awvalid = 1'b0;
		i_awaddr  = '0;
		i_awid    = '0;
		i_wvalid  = 1'b0;
		i_wdata   = '0;
		i_bready  = 1'b0;
		i_arvalid = 1'b0;
		i_araddr  = '0;
		i_arid    = '0;
		i_rready  = 1'b0;
		// external lines stay high until the routing test, only the enables mask them
		i_ext_irq = 4'hf;
		lfsr_q    = 32'hc5ba;
		repeat (2) @(posedge core_clk);
		rst_n <= 1'b1;

		// control block
		wdata = rand_bits(32);
		axi_write(LED_ADDR, wdata, OKAY);
		check_value("o_led", 32'(o_led), {28'd0, wdata[3:0]});
		axi_read(LED_ADDR, OKAY, rdata);
		check_value("o_rdata", rdata, {28'd0, wdata[3:0]});
		wdata = rand_bits(32);
		axi_write(SCRATCH_ADDR, wdata, OKAY);
		axi_read(SCRATCH_ADDR, OKAY, rdata);
		check_value("o_rdata", rdata, wdata);
		axi_read(COREID_ADDR, OKAY, rdata);
		check_value("o_rdata", rdata, 32'(CORE_ID));
		axi_write(COREID_ADDR, rand_bits(32), OKAY);
		axi_read(COREID_ADDR, OKAY, rdata);
		check_value("o_rdata", rdata, 32'(CORE_ID));

		// regions 3 and above are unmapped
		axi_write(BAD_ADDR_A, rand_bits(32), SLVERR);
		axi_read(BAD_ADDR_A, SLVERR, rdata);
		check_value("o_rdata", rdata, 32'd0);
		axi_read(BAD_ADDR_B, SLVERR, rdata);
		check_value("o_rdata", rdata, 32'd0);

		// one-shot timer on irq
		axi_write(ENABLE_ADDR, 32'h1, OKAY);
		axi_write(FSEL_ADDR, 32'h0, OKAY);
		axi_write(TLOAD_ADDR, 32'(LOAD_ONESHOT), OKAY);
		axi_write(TCTRL_ADDR, 32'h1, OKAY);
		waited = 0;
		while (!o_irq && waited < LOAD_ONESHOT + 4) begin
			@(posedge core_clk);
			waited++;
		end
		check_value("o_irq", 32'(o_irq), 32'd1);
		repeat (4) begin
			@(posedge core_clk);
			check_value("o_irq", 32'(o_irq), 32'd1);
		end
		axi_read(TVALUE_ADDR, OKAY, rdata);
		check_value("o_rdata", rdata, 32'd0);
		axi_read(TCTRL_ADDR, OKAY, rdata);
		check_value("o_rdata", 32'(rdata[0]), 32'd0);
		check_value("o_irq", 32'(o_irq), 32'd1);
		axi_write(TCLEAR_ADDR, 32'h1, OKAY);
		check_value("o_irq", 32'(o_irq), 32'd0);

		// expiry with the source masked
		axi_write(ENABLE_ADDR, 32'h0, OKAY);
		axi_write(TLOAD_ADDR, 32'(LOAD_MASKED), OKAY);
		axi_write(TCTRL_ADDR, 32'h1, OKAY);
		repeat (LOAD_MASKED + 4) begin
			@(posedge core_clk);
			check_value("o_irq", 32'(o_irq), 32'd0);
		end
		axi_read(STATUS_ADDR, OKAY, rdata);
		check_value("o_rdata", 32'(rdata[0]), 32'd1);
		axi_write(TCLEAR_ADDR, 32'h1, OKAY);

		// external lines routed by enable and firq select
		repeat (3) begin
			rnd = rand_bits(4);
			ext = rnd[3:0];
			rnd = rand_bits(8);
			en  = rnd[7:0];
			rnd = rand_bits(8);
			sel = rnd[7:0];
			@(posedge core_clk);
			i_ext_irq <= ext;
			axi_read(STATUS_ADDR, OKAY, rdata);
			check_value("o_rdata", 32'(rdata[7:4]), 32'(ext));
			axi_write(ENABLE_ADDR, 32'(en), OKAY);
			axi_write(FSEL_ADDR, 32'(sel), OKAY);
			// timer flag was cleared above
			exp_irq  = 1'b0;
			exp_firq = 1'b0;
			for (int i = 0; i < 4; i++) begin
				if (ext[i] && en[i+4]) begin
					if (sel[i+4])
						exp_firq = 1'b1;
					else
						exp_irq = 1'b1;
				end
			end
			@(posedge core_clk);
			check_value("o_irq", 32'(o_irq), 32'(exp_irq));
			check_value("o_firq", 32'(o_firq), 32'(exp_firq));
		end

		repeat (2) @(posedge core_clk);
		print_counts();
		if (assert_errs == 0 && value_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
